/* run.sh */
#!/bin/sh
# Build with Verilator, run the testbench into sim.log, then decide on the log contents
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module tb_core -o tb_core \
	&& ./obj_dir/tb_core > sim.log 2>&1 \
	|| echo "build or simulation exited with an error"
cat sim.log 2>/dev/null
grep -q "Result: PASSED" sim.log \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
exit 0

/* sim.f */
+incdir+verilog
verilog/core_pkg.sv
verilog/word_ram.sv
verilog/regfile.sv
verilog/exec_unit.sv
verilog/divider_unit.sv
verilog/core_sequencer.sv
verilog/apb_host_port.sv
verilog/core_top.sv
testbench/tb_core.sv

/* testbench/tb_core.sv */
`timescale 1ns/1ps
`default_nettype none

`include "core_settings.svh"

module tb_core;
	localparam int HALF_PERIOD  = 20;		// 40 ns clock
	localparam int DRIVE_DLY    = 2;
	localparam int PREADY_LIMIT = 8;
	localparam int POLL_LIMIT   = 4000;		// Status reads, two cycles each
	localparam int RES_BYTE     = 64;		// Result slots from dmem word 16
	localparam logic [31:0] ECALL = 32'h0000_0073;

	// Operations known to the reference model
	typedef enum int {
		OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLT, OP_SLTU,
		OP_DIV, OP_DIVU, OP_REM, OP_REMU
	} ref_op_t;

	logic               CLK = 1'b0;
	logic               rst_n;
	core_pkg::apb_req_t apb_req;
	core_pkg::apb_rsp_t apb_rsp;

	integer      seed;
	int          check_cnt, err_cnt, timeout_cnt;
	logic [31:0] prog [$];		// Program under construction
	string       name_q [$];		// Pending compares
	logic [31:0] got_q [$];
	logic [31:0] exp_q [$];
	string       chk_name;
	logic [31:0] chk_got, chk_exp;

	core_top DUT (.CLK(CLK), .rst_n(rst_n), .apb_req(apb_req), .apb_rsp(apb_rsp));

	always #(HALF_PERIOD) CLK = ~CLK;

	// RV32 encoders
	function automatic logic [31:0] encode_rr(input ref_op_t op, input logic [4:0] rd,
		input logic [4:0] rs1, input logic [4:0] rs2);
		logic [6:0] f7;
		logic [2:0] f3;
		f7 = `F7_BASE;
		case (op)
		OP_ADD, OP_SUB: f3 = 3'b000;
		OP_SLT:         f3 = 3'b010;
		OP_SLTU:        f3 = 3'b011;
		OP_XOR:         f3 = 3'b100;
		OP_OR:          f3 = 3'b110;
		OP_AND:         f3 = 3'b111;
		OP_DIV:         f3 = 3'b100;
		OP_DIVU:        f3 = 3'b101;
		OP_REM:         f3 = 3'b110;
		default:        f3 = 3'b111;		// REMU
		endcase
		if (op == OP_SUB)
			f7 = `F7_SUB;
		else if (op >= OP_DIV)
			f7 = `F7_MULDIV;			// M extension
		return {f7, rs2, rs1, f3, rd, `OPC_OP};
	endfunction

	function automatic logic [31:0] addi(input logic [4:0] rd, input logic [4:0] rs1,
		input logic [11:0] imm);
		return {imm, rs1, 3'b000, rd, `OPC_OP_IMM};
	endfunction

	function automatic logic [31:0] lw(input logic [4:0] rd, input logic [4:0] rs1,
		input logic [11:0] imm);
		return {imm, rs1, 3'b010, rd, `OPC_LOAD};
	endfunction

	function automatic logic [31:0] sw(input logic [4:0] rs2, input logic [4:0] rs1,
		input logic [11:0] imm);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], `OPC_STORE};	// S-type split
	endfunction

	function automatic logic [31:0] lui(input logic [4:0] rd, input logic [19:0] imm);
		return {imm, rd, `OPC_LUI};
	endfunction

	// Expected word per RV32IM rules
	function automatic logic [31:0] expected_result(input ref_op_t op, input logic [31:0] a,
		input logic [31:0] b);
		logic overflow;
		overflow = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
		if (op >= OP_DIV && b == 32'h0)		// Divide by zero
			return (op == OP_DIV || op == OP_DIVU) ? 32'hffff_ffff : a;
		if (overflow && op == OP_DIV)
			return a;
		if (overflow && op == OP_REM)
			return 32'h0;
		case (op)
		OP_ADD:  return a + b;
		OP_SUB:  return a - b;
		OP_AND:  return a & b;
		OP_OR:   return a | b;
		OP_XOR:  return a ^ b;
		OP_SLT:  return {31'b0, $signed(a) < $signed(b)};
		OP_SLTU: return {31'b0, a < b};
		OP_DIV:  return $signed(a) / $signed(b);	// Truncates toward zero
		OP_DIVU: return a / b;
		OP_REM:  return $signed(a) % $signed(b);	// Sign of dividend
		default: return a % b;
		endcase
	endfunction

	function automatic logic [`CORE_PADDR_W-1:0] dmem_addr(input int word);
		logic [`CORE_PADDR_W-1:0] offs;
		offs = word * 4;
		return `CORE_DMEM_BASE + offs;
	endfunction

	function automatic logic [`CORE_PADDR_W-1:0] imem_addr(input int word);
		logic [`CORE_PADDR_W-1:0] offs;
		offs = word * 4;
		return `CORE_IMEM_BASE + offs;
	endfunction

	// Compares run here, fed by the stimulus
	always @(negedge CLK) begin
		while (exp_q.size() > 0) begin
			chk_name = name_q.pop_front();
			chk_got  = got_q.pop_front();
			chk_exp  = exp_q.pop_front();
			check_cnt++;
			assert (chk_got === chk_exp) else begin
				err_cnt++;
				$display("[FAIL] %s: got %h expected %h", chk_name, chk_got, chk_exp);
			end
		end
	end

	task automatic finish_run();
		$display("Checks: %0d  errors: %0d  timeouts: %0d", check_cnt, err_cnt, timeout_cnt);
		if (err_cnt == 0 && timeout_cnt == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	endtask

	task automatic report_timeout(input string what);
		timeout_cnt++;
		$display("Timeout: %s", what);
	endtask

	task automatic expect_word(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		name_q.push_back(name);
		got_q.push_back(got);
		exp_q.push_back(exp);
	endtask

	// One transfer, called 2 ns after a rising edge
	task automatic apb_xfer(input logic write, input logic [`CORE_PADDR_W-1:0] addr,
		input logic [31:0] wdata, output logic [31:0] rdata, output logic slverr);
		int waited;
		apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: addr, pwdata: wdata};
		@(posedge CLK);
		#(DRIVE_DLY);
		apb_req.penable = 1'b1;		// Access phase
		@(negedge CLK);
		for (waited = 0; !apb_rsp.pready && waited < PREADY_LIMIT; waited++)
			@(negedge CLK);
		if (!apb_rsp.pready)
			report_timeout("APB access phase never saw pready");
		rdata  = apb_rsp.prdata;		// Mid-cycle, stable
		slverr = apb_rsp.pslverr;
		@(posedge CLK);
		#(DRIVE_DLY);
		apb_req = '0;
	endtask

	task automatic apb_write(input logic [`CORE_PADDR_W-1:0] addr, input logic [31:0] wdata);
		logic [31:0] rdata;
		logic        slverr;
		apb_xfer(1'b1, addr, wdata, rdata, slverr);
		expect_word("pslverr", {31'b0, slverr}, 32'h0);
	endtask

	task automatic check_read(input string name, input logic [`CORE_PADDR_W-1:0] addr,
		input logic [31:0] exp);
		logic [31:0] rdata;
		logic        slverr;
		apb_xfer(1'b0, addr, 32'h0, rdata, slverr);
		expect_word("pslverr", {31'b0, slverr}, 32'h0);
		expect_word(name, rdata, exp);
	endtask

	task automatic expect_refusal(input logic write, input logic [`CORE_PADDR_W-1:0] addr,
		input logic [31:0] wdata);
		logic [31:0] rdata;
		logic        slverr;
		apb_xfer(write, addr, wdata, rdata, slverr);
		expect_word("pslverr", {31'b0, slverr}, 32'h1);
	endtask

	task automatic load_program();
		int i;
		for (i = 0; i < prog.size(); i++)
			apb_write(imem_addr(i), prog[i]);
	endtask

	task automatic start_core();
		apb_write(`CORE_CTRL_ADDR, 32'h1);
	endtask

	task automatic wait_halted();
		logic [31:0] status;
		logic        slverr;
		int          polls;
		status = '0;
		for (polls = 0; polls < POLL_LIMIT && !status[1]; polls++)
			apb_xfer(1'b0, `CORE_CTRL_ADDR, 32'h0, status, slverr);
		if (!status[1])
			report_timeout("core never reported halted");
	endtask

	task automatic reset_state_and_ram();
		logic [31:0] words [4];
		int          k;
		check_read("ctrl prdata", `CORE_CTRL_ADDR, 32'h0);	// Idle, not halted
		for (k = 0; k < 4; k++) begin
			words[k] = $random(seed);
			apb_write(dmem_addr(200 + k), words[k]);
		end
		apb_write(imem_addr(250), ~words[0]);
		for (k = 0; k < 4; k++)
			check_read("dmem prdata", dmem_addr(200 + k), words[k]);
		check_read("imem prdata", imem_addr(250), ~words[0]);
	endtask

	task automatic alu_program();
		logic [31:0] a, b;
		logic [11:0] imm12;
		logic [19:0] imm20;
		ref_op_t     op;
		int          k;
		a     = $random(seed);
		b     = $random(seed);
		imm12 = 12'($random(seed));
		imm20 = 20'($random(seed));
		apb_write(dmem_addr(0), a);
		apb_write(dmem_addr(1), b);
		prog.delete();
		prog.push_back(lw(5'd1, 5'd0, 12'd0));
		prog.push_back(lw(5'd2, 5'd0, 12'd4));
		for (k = 0; k <= int'(OP_SLTU); k++) begin	// ADD through SLTU
			prog.push_back(encode_rr(ref_op_t'(k), 5'd3, 5'd1, 5'd2));
			prog.push_back(sw(5'd3, 5'd0, 12'(RES_BYTE + 4 * k)));
		end
		prog.push_back(addi(5'd3, 5'd1, imm12));
		prog.push_back(sw(5'd3, 5'd0, 12'(RES_BYTE + 28)));
		prog.push_back(lui(5'd3, imm20));
		prog.push_back(sw(5'd3, 5'd0, 12'(RES_BYTE + 32)));
		prog.push_back(ECALL);
		load_program();
		start_core();
		wait_halted();
		check_read("ctrl prdata", `CORE_CTRL_ADDR, 32'h2);
		for (k = 0; k <= int'(OP_SLTU); k++) begin
			op = ref_op_t'(k);
			check_read($sformatf("prdata %s", op.name()), dmem_addr(16 + k),
				expected_result(op, a, b));
		end
		check_read("prdata ADDI", dmem_addr(23),
			expected_result(OP_ADD, a, {{20{imm12[11]}}, imm12}));
		check_read("prdata LUI", dmem_addr(24), expected_result(OP_ADD, 32'h0, {imm20, 12'h0}));
	endtask

	task automatic divide_program();
		logic [31:0] da [6];
		logic [31:0] db [6];
		ref_op_t     op;
		int          p, k;
		for (p = 0; p < 4; p++) begin
			da[p] = $random(seed);
			db[p] = $signed($random(seed)) >>> (7 * p);	// Smaller divisors, larger quotients
		end
		da[4] = $random(seed);
		db[4] = 32'h0;
		da[5] = 32'h8000_0000;		// Signed overflow case
		db[5] = 32'hffff_ffff;
		prog.delete();
		for (p = 0; p < 6; p++) begin
			apb_write(dmem_addr(2 * p), da[p]);
			apb_write(dmem_addr(2 * p + 1), db[p]);
			prog.push_back(lw(5'd1, 5'd0, 12'(8 * p)));
			prog.push_back(lw(5'd2, 5'd0, 12'(8 * p + 4)));
			for (k = 0; k < 4; k++) begin
				prog.push_back(encode_rr(ref_op_t'(int'(OP_DIV) + k), 5'd3, 5'd1, 5'd2));
				prog.push_back(sw(5'd3, 5'd0, 12'(128 + 16 * p + 4 * k)));
			end
		end
		prog.push_back(ECALL);
		load_program();
		start_core();
		wait_halted();
		check_read("ctrl prdata", `CORE_CTRL_ADDR, 32'h2);
		for (p = 0; p < 6; p++)
			for (k = 0; k < 4; k++) begin
				op = ref_op_t'(int'(OP_DIV) + k);
				check_read($sformatf("prdata %s", op.name()),
					dmem_addr(32 + 4 * p + k),
					expected_result(op, da[p], db[p]));
			end
	endtask

	task automatic x0_stays_zero();
		apb_write(dmem_addr(0), 32'h1357_9bdf);
		apb_write(dmem_addr(8), 32'h5a5a_c3c3);		// Overwritten only by the store
		prog.delete();
		prog.push_back(lw(5'd1, 5'd0, 12'd0));
		prog.push_back(addi(5'd0, 5'd1, 12'h7ff));
		prog.push_back(encode_rr(OP_ADD, 5'd0, 5'd1, 5'd1));
		prog.push_back(lw(5'd0, 5'd0, 12'd0));
		prog.push_back(sw(5'd0, 5'd0, 12'd32));
		prog.push_back(ECALL);
		load_program();
		start_core();
		wait_halted();
		check_read("prdata x0 store", dmem_addr(8), 32'h0);
	endtask

	task automatic host_refused_while_running();
		logic [31:0] a, b;
		int          k;
		a = $random(seed);
		b = $random(seed) | 32'h1;
		apb_write(dmem_addr(0), a);
		apb_write(dmem_addr(1), b);
		apb_write(dmem_addr(16), 32'h0);		// Stays zero if the core stops early
		expect_refusal(1'b0, 12'hc00, 32'h0);	// Unmapped, core idle
		expect_refusal(1'b1, 12'h804, 32'h1);
		prog.delete();
		prog.push_back(lw(5'd1, 5'd0, 12'd0));
		prog.push_back(lw(5'd2, 5'd0, 12'd4));
		for (k = 0; k < 40; k++)
			prog.push_back(encode_rr(OP_DIV, 5'd3, 5'd1, 5'd2));
		prog.push_back(sw(5'd3, 5'd0, 12'(RES_BYTE)));
		prog.push_back(ECALL);
		load_program();
		start_core();
		check_read("ctrl prdata", `CORE_CTRL_ADDR, 32'h1);	// Running
		expect_refusal(1'b0, dmem_addr(0), 32'h0);
		expect_refusal(1'b1, imem_addr(30), ECALL);		// Would cut the loop short
		expect_refusal(1'b1, `CORE_CTRL_ADDR, 32'h1);
		expect_refusal(1'b0, 12'hc00, 32'h0);
		check_read("ctrl prdata", `CORE_CTRL_ADDR, 32'h1);
		wait_halted();
		check_read("ctrl prdata", `CORE_CTRL_ADDR, 32'h2);
		check_read("prdata DIV loop", dmem_addr(16), expected_result(OP_DIV, a, b));
		check_read("imem prdata", imem_addr(30), encode_rr(OP_DIV, 5'd3, 5'd1, 5'd2));
		check_read("dmem prdata", dmem_addr(0), a);
		expect_refusal(1'b0, 12'hc00, 32'h0);	// Unmapped after halt too
	endtask

	task automatic drain_checks();
		int waited;
		for (waited = 0; exp_q.size() > 0 && waited < 10; waited++)
			@(posedge CLK);
		if (exp_q.size() > 0)
			report_timeout("checker queue never emptied");
	endtask

	initial begin
		seed        = 32'h83a1_6adf;
		check_cnt   = 0;
		err_cnt     = 0;
		timeout_cnt = 0;
		rst_n       = 1'b0;
		apb_req     = '0;
		repeat (2) @(posedge CLK);
		#(DRIVE_DLY);
		rst_n = 1'b1;
		reset_state_and_ram();
		repeat (3) alu_program();		// Fresh operands each round
		divide_program();
		x0_stays_zero();
		host_refused_while_running();
		drain_checks();
		finish_run();
	end

endmodule

`default_nettype wire

/* verilog/apb_host_port.sv */
`timescale 1ns/1ps
`default_nettype none

`include "core_settings.svh"

module apb_host_port (
	input  logic                  CLK,
	input  logic                  rst_n,
	input  core_pkg::apb_req_t    apb_req,
	output core_pkg::apb_rsp_t    apb_rsp,
	input  logic                  running,
	input  logic                  halted,
	output logic                  start,
	input  core_pkg::mem_req_t    core_imem_req,
	input  core_pkg::mem_req_t    core_dmem_req,
	output core_pkg::mem_req_t    imem_req,
	output core_pkg::mem_req_t    dmem_req,
	input  logic [`CORE_XLEN-1:0] imem_rdata,
	input  logic [`CORE_XLEN-1:0] dmem_rdata
);
	localparam int WIN = `CORE_MEM_AW + 2;		// Byte offset bits inside one memory
	localparam logic [`CORE_PADDR_W-1:0] IMEM_BASE = `CORE_IMEM_BASE;
	localparam logic [`CORE_PADDR_W-1:0] DMEM_BASE = `CORE_DMEM_BASE;

	logic               setup, access;
	logic               hit_imem, hit_dmem, hit_ctrl;
	logic               err_now;		// Refusal decided in setup
	logic               err_q;
	core_pkg::mem_req_t host_req;

	assign setup  = apb_req.psel && !apb_req.penable;
	assign access = apb_req.psel && apb_req.penable;

	assign hit_imem = apb_req.paddr[`CORE_PADDR_W-1:WIN] == IMEM_BASE[`CORE_PADDR_W-1:WIN];
	assign hit_dmem = apb_req.paddr[`CORE_PADDR_W-1:WIN] == DMEM_BASE[`CORE_PADDR_W-1:WIN];
	assign hit_ctrl = apb_req.paddr == `CORE_CTRL_ADDR;

	// Unmapped, memory while running, or start while running
	assign err_now = !(hit_imem || hit_dmem || hit_ctrl) ||
		((hit_imem || hit_dmem) && running) ||
		(hit_ctrl && apb_req.pwrite && apb_req.pwdata[0] && running);

	always_ff @(posedge CLK) begin
		if (!rst_n)
			err_q <= 1'b0;
		else if (setup)
			err_q <= err_now;
	end

	// Seen by the sequencer in the access cycle, so running is up for the next setup
	assign start = access && apb_req.pwrite && hit_ctrl && !err_q && apb_req.pwdata[0];

	// Reads launch in setup, writes commit in access
	assign host_req.en = (setup && !apb_req.pwrite && !err_now) ||
		(access && apb_req.pwrite && !err_q);
	assign host_req.we    = apb_req.pwrite;
	assign host_req.addr  = apb_req.paddr[WIN-1:2];
	assign host_req.wdata = apb_req.pwdata;

	always_comb begin
		imem_req    = host_req;
		imem_req.en = host_req.en && hit_imem;
		dmem_req    = host_req;
		dmem_req.en = host_req.en && hit_dmem;
		if (running) begin		// Core owns both RAMs
			imem_req = core_imem_req;
			dmem_req = core_dmem_req;
		end
	end

	always_comb begin
		apb_rsp.prdata = '0;
		if (access && !err_q) begin
			if (hit_ctrl)
				apb_rsp.prdata = {{(`CORE_XLEN-2){1'b0}}, halted, running};
			else if (hit_imem)
				apb_rsp.prdata = imem_rdata;
			else
				apb_rsp.prdata = dmem_rdata;
		end
		apb_rsp.pready  = 1'b1;		// No wait states
		apb_rsp.pslverr = access && err_q;
	end

	// An error only ends a transfer that had a setup phase
	assert property (@(posedge CLK) disable iff (!rst_n)
		$rose(apb_rsp.pslverr) |-> apb_req.penable && $past(setup));

endmodule

`default_nettype wire

/* verilog/core_pkg.sv */
`default_nettype none

`include "core_settings.svh"

package core_pkg;

	// Host side bus
	typedef struct packed {
		logic                     psel;
		logic                     penable;
		logic                     pwrite;
		logic [`CORE_PADDR_W-1:0] paddr;
		logic [`CORE_XLEN-1:0]    pwdata;
	} apb_req_t;

	typedef struct packed {
		logic [`CORE_XLEN-1:0] prdata;
		logic                  pready;
		logic                  pslverr;
	} apb_rsp_t;

	// One RAM port, word addressed
	typedef struct packed {
		logic                   en;
		logic                   we;
		logic [`CORE_MEM_AW-1:0] addr;
		logic [`CORE_XLEN-1:0]  wdata;
	} mem_req_t;

	typedef enum logic [2:0] {
		ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_SLTU, ALU_PASS_B
	} alu_op_t;

	// Order follows funct3[1:0] of the M extension
	typedef enum logic [1:0] {
		DIVOP_DIV, DIVOP_DIVU, DIVOP_REM, DIVOP_REMU
	} div_op_t;

	typedef enum logic [2:0] {
		CLS_ALU, CLS_LOAD, CLS_STORE, CLS_DIVIDE, CLS_HALT, CLS_ILLEGAL
	} op_class_t;

	typedef struct packed {
		op_class_t             op_class;
		alu_op_t               alu_op;
		div_op_t               div_op;
		logic [4:0]            rd;
		logic [4:0]            rs1;
		logic [4:0]            rs2;
		logic [`CORE_XLEN-1:0] imm;
	} decoded_t;

	typedef enum logic [2:0] {
		S_IDLE, S_FETCH, S_EXEC, S_MEM, S_DIV_WAIT, S_WRITE, S_HALTED
	} seq_state_t;

endpackage

`default_nettype wire

/* verilog/core_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "core_settings.svh"

module core_sequencer (
	input  logic                  CLK,
	input  logic                  rst_n,
	input  logic                  start,
	input  logic [`CORE_XLEN-1:0] instr,
	input  core_pkg::decoded_t    dec,
	input  logic [`CORE_XLEN-1:0] alu_result,
	input  logic [`CORE_XLEN-1:0] rs2_data,
	input  logic                  div_done,
	input  logic [`CORE_XLEN-1:0] div_result,
	input  logic [`CORE_XLEN-1:0] dmem_rdata,
	output core_pkg::mem_req_t    imem_req,
	output core_pkg::mem_req_t    dmem_req,
	output logic                  rf_we,
	output logic [4:0]            rf_waddr,
	output logic [`CORE_XLEN-1:0] rf_wdata,
	output logic                  div_start,
	output logic                  running,
	output logic                  halted
);
	core_pkg::seq_state_t  state;
	logic [`CORE_XLEN-1:0] pc;		// Byte address
	logic [`CORE_XLEN-1:0] ir;		// Latched in EXEC

	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			state <= core_pkg::S_IDLE;
			pc    <= '0;
		end else begin
			case (state)
			core_pkg::S_IDLE, core_pkg::S_HALTED: begin
				if (start) begin		// Always from PC 0
					state <= core_pkg::S_FETCH;
					pc    <= '0;
				end
			end
			core_pkg::S_FETCH: state <= core_pkg::S_EXEC;
			core_pkg::S_EXEC: begin
				pc <= pc + `CORE_XLEN'(4);
				case (dec.op_class)
				core_pkg::CLS_ALU:                     state <= core_pkg::S_WRITE;
				core_pkg::CLS_LOAD, core_pkg::CLS_STORE: state <= core_pkg::S_MEM;
				core_pkg::CLS_DIVIDE:                  state <= core_pkg::S_DIV_WAIT;
				default:                               state <= core_pkg::S_HALTED; // ECALL, illegal
				endcase
			end
			core_pkg::S_MEM:      state <= core_pkg::S_WRITE;
			core_pkg::S_DIV_WAIT: if (div_done) state <= core_pkg::S_FETCH;	// Written back here
			core_pkg::S_WRITE:    state <= core_pkg::S_FETCH;
			default:              state <= core_pkg::S_IDLE;
			endcase
		end
	end

	always_ff @(posedge CLK) begin
		if (state == core_pkg::S_EXEC)
			ir <= instr;
	end

	// Fetch port, read only
	assign imem_req.en    = (state == core_pkg::S_FETCH);
	assign imem_req.we    = 1'b0;
	assign imem_req.addr  = pc[`CORE_MEM_AW+1:2];
	assign imem_req.wdata = '0;

	// Word loads and stores at the ALU address
	assign dmem_req.en    = (state == core_pkg::S_MEM);
	assign dmem_req.we    = (dec.op_class == core_pkg::CLS_STORE);
	assign dmem_req.addr  = alu_result[`CORE_MEM_AW+1:2];
	assign dmem_req.wdata = rs2_data;

	assign div_start = (state == core_pkg::S_EXEC) && (dec.op_class == core_pkg::CLS_DIVIDE);

	// Write-back
	assign rf_we = ((state == core_pkg::S_WRITE) && (dec.op_class != core_pkg::CLS_STORE)) ||
		((state == core_pkg::S_DIV_WAIT) && div_done);
	assign rf_waddr = ir[11:7];
	assign rf_wdata = (state == core_pkg::S_DIV_WAIT) ? div_result :
		(dec.op_class == core_pkg::CLS_LOAD) ? dmem_rdata : alu_result;

	assign halted  = (state == core_pkg::S_HALTED);
	assign running = (state != core_pkg::S_IDLE) && !halted;

	// A run ends only by halting, never by dropping back to idle
	assert property (@(posedge CLK) disable iff (!rst_n) $fell(running) |-> halted);

	// A divide launched from EXEC is answered after the full step count
	assert property (@(posedge CLK) disable iff (!rst_n)
		div_start |-> (state == core_pkg::S_EXEC) ##(`CORE_DIV_STEPS + 1) div_done);

endmodule

`default_nettype wire

/* verilog/core_settings.svh */
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// Datapath and memory sizes
`define CORE_XLEN        32
`define CORE_IMEM_WORDS  256
`define CORE_DMEM_WORDS  256
`define CORE_MEM_AW      8          // Word address bits, covers both memories

// APB address map
`define CORE_PADDR_W     12
`define CORE_IMEM_BASE   12'h000
`define CORE_DMEM_BASE   12'h400
`define CORE_CTRL_ADDR   12'h800

// One quotient bit per iteration
`define CORE_DIV_STEPS   32

// RV32 opcodes
`define OPC_OP           7'b0110011
`define OPC_OP_IMM       7'b0010011
`define OPC_LUI          7'b0110111
`define OPC_LOAD         7'b0000011
`define OPC_STORE        7'b0100011
`define OPC_SYSTEM       7'b1110011

// funct7 values
`define F7_BASE          7'b0000000
`define F7_SUB           7'b0100000
`define F7_MULDIV        7'b0000001

`endif

/* verilog/core_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "core_settings.svh"

module core_top (
	input  logic               CLK,
	input  logic               rst_n,
	input  core_pkg::apb_req_t apb_req,
	output core_pkg::apb_rsp_t apb_rsp
);
	logic                  start, running, halted;
	core_pkg::mem_req_t    core_imem_req, core_dmem_req;	// From sequencer
	core_pkg::mem_req_t    imem_req, dmem_req;			// After host mux
	logic [`CORE_XLEN-1:0] imem_rdata, dmem_rdata;
	core_pkg::decoded_t    dec;
	logic [`CORE_XLEN-1:0] alu_result;
	logic [`CORE_XLEN-1:0] rs1_data, rs2_data;
	logic                  rf_we;
	logic [4:0]            rf_waddr;
	logic [`CORE_XLEN-1:0] rf_wdata;
	logic                  div_start, div_done;
	logic [`CORE_XLEN-1:0] div_result;

	apb_host_port host (
		.CLK(CLK), .rst_n(rst_n),
		.apb_req(apb_req), .apb_rsp(apb_rsp),
		.running(running), .halted(halted), .start(start),
		.core_imem_req(core_imem_req), .core_dmem_req(core_dmem_req),
		.imem_req(imem_req), .dmem_req(dmem_req),
		.imem_rdata(imem_rdata), .dmem_rdata(dmem_rdata)
	);

	core_sequencer seq (
		.CLK(CLK), .rst_n(rst_n), .start(start),
		.instr(imem_rdata), .dec(dec),		// Fetched word stays on the RAM output
		.alu_result(alu_result), .rs2_data(rs2_data),
		.div_done(div_done), .div_result(div_result), .dmem_rdata(dmem_rdata),
		.imem_req(core_imem_req), .dmem_req(core_dmem_req),
		.rf_we(rf_we), .rf_waddr(rf_waddr), .rf_wdata(rf_wdata),
		.div_start(div_start), .running(running), .halted(halted)
	);

	exec_unit exu (
		.instr(imem_rdata), .rs1_data(rs1_data), .rs2_data(rs2_data),
		.dec(dec), .alu_result(alu_result)
	);

	regfile rf (
		.CLK(CLK), .rst_n(rst_n),
		.rs1(dec.rs1), .rs2(dec.rs2),
		.rs1_data(rs1_data), .rs2_data(rs2_data),
		.we(rf_we), .waddr(rf_waddr), .wdata(rf_wdata)
	);

	divider_unit div (
		.CLK(CLK), .rst_n(rst_n),
		.div_start(div_start), .div_op(dec.div_op),
		.dividend(rs1_data), .divisor(rs2_data),
		.div_done(div_done), .div_result(div_result)
	);

	word_ram #(.DEPTH(`CORE_IMEM_WORDS)) imem (.CLK(CLK), .req(imem_req), .rdata(imem_rdata));
	word_ram #(.DEPTH(`CORE_DMEM_WORDS)) dmem (.CLK(CLK), .req(dmem_req), .rdata(dmem_rdata));

endmodule

`default_nettype wire

/* verilog/divider_unit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "core_settings.svh"

module divider_unit (
	input  logic                  CLK,
	input  logic                  rst_n,
	input  logic                  div_start,
	input  core_pkg::div_op_t     div_op,
	input  logic [`CORE_XLEN-1:0] dividend,
	input  logic [`CORE_XLEN-1:0] divisor,
	output logic                  div_done,
	output logic [`CORE_XLEN-1:0] div_result
);
	localparam int CW = $clog2(`CORE_DIV_STEPS);

	logic                  busy;
	logic [CW-1:0]         count;
	logic                  last_step;
	logic                  is_signed;
	logic [`CORE_XLEN-1:0] a_mag, b_mag;		// Operand magnitudes
	logic [`CORE_XLEN-1:0] quo, rem, dsor;
	logic                  neg_q, neg_r, want_rem;
	logic [`CORE_XLEN:0]   rem_shift, trial;
	logic [`CORE_XLEN-1:0] quo_next, rem_next;

	assign is_signed = (div_op == core_pkg::DIVOP_DIV) || (div_op == core_pkg::DIVOP_REM);
	assign a_mag = (is_signed && dividend[`CORE_XLEN-1]) ? -dividend : dividend;
	assign b_mag = (is_signed && divisor[`CORE_XLEN-1]) ? -divisor : divisor;

	// One restoring step
	assign rem_shift = {rem, quo[`CORE_XLEN-1]};
	assign trial     = rem_shift - {1'b0, dsor};
	assign quo_next  = {quo[`CORE_XLEN-2:0], ~trial[`CORE_XLEN]};
	assign rem_next  = trial[`CORE_XLEN] ? rem_shift[`CORE_XLEN-1:0] : trial[`CORE_XLEN-1:0];
	assign last_step = busy && (count == CW'(`CORE_DIV_STEPS - 1));

	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			busy     <= 1'b0;
			count    <= '0;
			div_done <= 1'b0;
		end else begin
			div_done <= last_step;		// Single cycle pulse
			if (div_start) begin
				busy  <= 1'b1;
				count <= '0;
			end else if (busy) begin
				count <= count + 1'b1;
				if (last_step)
					busy <= 1'b0;
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (div_start) begin
			quo      <= a_mag;
			rem      <= '0;
			dsor     <= b_mag;
			// Zero divisor keeps the all ones quotient unsigned
			neg_q    <= is_signed && (dividend[`CORE_XLEN-1] ^ divisor[`CORE_XLEN-1]) && |divisor;
			neg_r    <= is_signed && dividend[`CORE_XLEN-1];	// Remainder follows dividend
			want_rem <= (div_op == core_pkg::DIVOP_REM) || (div_op == core_pkg::DIVOP_REMU);
		end else if (busy) begin
			quo <= quo_next;
			rem <= rem_next;
			// Sign fix-up; most negative over -1 falls out as dividend, rem 0
			if (last_step)
				div_result <= want_rem ? (neg_r ? -rem_next : rem_next)
					: (neg_q ? -quo_next : quo_next);
		end
	end

	// Sequencer must wait for div_done before the next divide
	assert property (@(posedge CLK) disable iff (!rst_n) div_start |-> !busy);

endmodule

`default_nettype wire

/* verilog/exec_unit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "core_settings.svh"

module exec_unit (
	input  logic [`CORE_XLEN-1:0] instr,
	input  logic [`CORE_XLEN-1:0] rs1_data,
	input  logic [`CORE_XLEN-1:0] rs2_data,
	output core_pkg::decoded_t    dec,
	output logic [`CORE_XLEN-1:0] alu_result
);
	logic [6:0]            opcode;
	logic [2:0]            funct3;
	logic [6:0]            funct7;
	logic                  use_imm;		// Operand B from immediate
	logic [`CORE_XLEN-1:0] op_b;

	assign opcode = instr[6:0];
	assign funct3 = instr[14:12];
	assign funct7 = instr[31:25];

	always_comb begin
		dec          = '0;
		dec.op_class = core_pkg::CLS_ILLEGAL;
		dec.alu_op   = core_pkg::ALU_ADD;
		dec.div_op   = core_pkg::div_op_t'(funct3[1:0]);
		dec.rd       = instr[11:7];
		dec.rs1      = instr[19:15];
		dec.rs2      = instr[24:20];
		dec.imm      = {{20{instr[31]}}, instr[31:20]};	// I-type
		use_imm      = 1'b1;
		case (opcode)
		`OPC_OP: begin
			use_imm = 1'b0;
			if (funct7 == `F7_MULDIV && funct3[2]) begin
				dec.op_class = core_pkg::CLS_DIVIDE;
			end else if (funct7 == `F7_BASE || (funct7 == `F7_SUB && funct3 == 3'b000)) begin
				dec.op_class = core_pkg::CLS_ALU;
				case (funct3)
				3'b000:  dec.alu_op = funct7[5] ? core_pkg::ALU_SUB : core_pkg::ALU_ADD;
				3'b010:  dec.alu_op = core_pkg::ALU_SLT;
				3'b011:  dec.alu_op = core_pkg::ALU_SLTU;
				3'b100:  dec.alu_op = core_pkg::ALU_XOR;
				3'b110:  dec.alu_op = core_pkg::ALU_OR;
				3'b111:  dec.alu_op = core_pkg::ALU_AND;
				default: dec.op_class = core_pkg::CLS_ILLEGAL;	// No shifts
				endcase
			end
		end
		`OPC_OP_IMM: if (funct3 == 3'b000) dec.op_class = core_pkg::CLS_ALU;	// ADDI only
		`OPC_LUI: begin
			dec.op_class = core_pkg::CLS_ALU;
			dec.alu_op   = core_pkg::ALU_PASS_B;
			dec.imm      = {instr[31:12], 12'b0};
		end
		`OPC_LOAD: if (funct3 == 3'b010) dec.op_class = core_pkg::CLS_LOAD;	// LW
		`OPC_STORE: begin
			dec.imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};	// S-type
			if (funct3 == 3'b010)
				dec.op_class = core_pkg::CLS_STORE;
		end
		`OPC_SYSTEM: if (instr[31:7] == '0) dec.op_class = core_pkg::CLS_HALT;	// ECALL
		default: ;
		endcase
	end

	assign op_b = use_imm ? dec.imm : rs2_data;

	// Loads and stores get their address from ADD
	always_comb begin
		case (dec.alu_op)
		core_pkg::ALU_ADD:  alu_result = rs1_data + op_b;
		core_pkg::ALU_SUB:  alu_result = rs1_data - op_b;
		core_pkg::ALU_AND:  alu_result = rs1_data & op_b;
		core_pkg::ALU_OR:   alu_result = rs1_data | op_b;
		core_pkg::ALU_XOR:  alu_result = rs1_data ^ op_b;
		core_pkg::ALU_SLT:  alu_result = {{(`CORE_XLEN-1){1'b0}}, $signed(rs1_data) < $signed(op_b)};
		core_pkg::ALU_SLTU: alu_result = {{(`CORE_XLEN-1){1'b0}}, rs1_data < op_b};
		default:            alu_result = op_b;		// LUI
		endcase
	end

endmodule

`default_nettype wire

/* verilog/regfile.sv */
`timescale 1ns/1ps
`default_nettype none

`include "core_settings.svh"

module regfile (
	input  logic                  CLK,
	input  logic                  rst_n,
	input  logic [4:0]            rs1,
	input  logic [4:0]            rs2,
	output logic [`CORE_XLEN-1:0] rs1_data,
	output logic [`CORE_XLEN-1:0] rs2_data,
	input  logic                  we,
	input  logic [4:0]            waddr,
	input  logic [`CORE_XLEN-1:0] wdata
);
	logic [`CORE_XLEN-1:0] regs [32];

	// Asynchronous reads, x0 stays at its reset value
	assign rs1_data = regs[rs1];
	assign rs2_data = regs[rs2];

	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end else if (we && (waddr != 5'd0)) begin	// x0 writes dropped
			regs[waddr] <= wdata;
		end
	end

endmodule

`default_nettype wire

/* verilog/word_ram.sv */
`timescale 1ns/1ps
`default_nettype none

`include "core_settings.svh"

module word_ram #(
	parameter int DEPTH = 256		// Power of two, at most 2**CORE_MEM_AW
) (
	input  logic                  CLK,
	input  core_pkg::mem_req_t    req,
	output logic [`CORE_XLEN-1:0] rdata
);
	localparam int AW = $clog2(DEPTH);

	logic [`CORE_XLEN-1:0] mem [DEPTH];

	// Read data lands one cycle later and holds while idle
	always_ff @(posedge CLK) begin
		if (req.en) begin
			if (req.we)
				mem[req.addr[AW-1:0]] <= req.wdata;
			rdata <= mem[req.addr[AW-1:0]];	// Old word on a write
		end
	end

endmodule

`default_nettype wire
